// ==== hw/execCore.sv ====
`timescale 1ns/10ps
`include "regFile_config.svh"

module execCore (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            hold,     // Freezes all state
	input  logic                            issueValid,
	input  logic [execOpPkg::INSN_WIDTH-1:0] issueWord,
	input  logic [`REG_IMM_WIDTH-1:0]       issueImm,
	input  logic [`REG_PC_WIDTH-1:0]        gbrVal,
	input  logic [`REG_DATA_WIDTH-1:0]      lrVal,
	output logic                            wbValid,
	output regIdPkg::regId                  wbId,     // EX3 destination
	output logic [`REG_DATA_WIDTH-1:0]      wbValue,  // EX3 result
	output logic [`REG_DATA_WIDTH-1:0]      sprSp
);

	regIdPkg::regId             idRs;
	regIdPkg::regId             idRt;
	regIdPkg::regId             idRm;
	regIdPkg::regId             idRn;
	execOpPkg::aluOp            idOp;
	logic [`REG_IMM_WIDTH-1:0]  idImm;
	logic [`REG_PC_WIDTH-1:0]   idPc;
	logic                       idValid;
	logic [`REG_DATA_WIDTH-1:0] valRs;
	logic [`REG_DATA_WIDTH-1:0] valRt;
	logic [`REG_DATA_WIDTH-1:0] valRm;
	regIdPkg::regId             rn1Id;
	regIdPkg::regId             rn2Id;
	logic [`REG_DATA_WIDTH-1:0] rn1Val;
	logic [`REG_DATA_WIDTH-1:0] rn2Val;

	issueDecode issueDecode_inst (
		.clock(clock), .reset(reset), .hold(hold),
		.issueValid(issueValid), .issueWord(issueWord), .issueImm(issueImm),
		.idRs(idRs), .idRt(idRt), .idRm(idRm), .idRn(idRn),
		.idOp(idOp), .idImm(idImm), .idPc(idPc), .idValid(idValid)
	);

	regFile regFile_inst (
		.clock(clock), .reset(reset), .hold(hold),
		.idRs(idRs), .idRt(idRt), .idRm(idRm),
		.rn1Id(rn1Id), .rn2Id(rn2Id), .rn3Id(wbId),
		.rn1Val(rn1Val), .rn2Val(rn2Val), .rn3Val(wbValue),
		.pcVal(idPc), .gbrVal(gbrVal), .lrVal(lrVal), .immVal(idImm),
		.valRs(valRs), .valRt(valRt), .valRm(valRm), .sprSp(sprSp)
	);

	execPipe execPipe_inst (
		.clock(clock), .reset(reset), .hold(hold),
		.idValid(idValid), .idRn(idRn), .idOp(idOp),
		.valRs(valRs), .valRt(valRt), .valRm(valRm),
		.rn1Id(rn1Id), .rn2Id(rn2Id), .rn3Id(wbId),
		.rn1Val(rn1Val), .rn2Val(rn2Val), .rn3Val(wbValue),
		.wbValid(wbValid)
	);

endmodule

// ==== hw/execOpPkg.sv ====
package execOpPkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SHL  = 4'h5,
		OP_SHR  = 4'h6,                      // Logical shift
		OP_MOV  = 4'h7,
		OP_CSEL = 4'h8                       // Rt != 0 ? Rs : Rm
	} aluOp;

	localparam int INSN_WIDTH = 32;

	// Field positions in the instruction word, bits 3:0 reserved
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 28;
	localparam int RN_MSB = 27;
	localparam int RN_LSB = 22;
	localparam int RS_MSB = 21;
	localparam int RS_LSB = 16;
	localparam int RT_MSB = 15;
	localparam int RT_LSB = 10;
	localparam int RM_MSB = 9;
	localparam int RM_LSB = 4;

endpackage

// ==== hw/execPipe.sv ====
`timescale 1ns/10ps
`include "regFile_config.svh"

module execPipe (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        hold,
	input  logic                        idValid,
	input  regIdPkg::regId              idRn,
	input  execOpPkg::aluOp             idOp,
	input  logic [`REG_DATA_WIDTH-1:0]  valRs,
	input  logic [`REG_DATA_WIDTH-1:0]  valRt,
	input  logic [`REG_DATA_WIDTH-1:0]  valRm,
	output regIdPkg::regId              rn1Id,
	output regIdPkg::regId              rn2Id,
	output regIdPkg::regId              rn3Id,
	output logic [`REG_DATA_WIDTH-1:0]  rn1Val,
	output logic [`REG_DATA_WIDTH-1:0]  rn2Val,
	output logic [`REG_DATA_WIDTH-1:0]  rn3Val,
	output logic                        wbValid
);

	localparam int SHIFT_BITS = $clog2(`REG_DATA_WIDTH);

	logic [`REG_DATA_WIDTH-1:0] aluResult;
	logic                       ex1Valid;
	logic                       ex2Valid;

	always_comb begin
		case (idOp)
			execOpPkg::OP_ADD:  aluResult = valRs + valRt;
			execOpPkg::OP_SUB:  aluResult = valRs - valRt;
			execOpPkg::OP_AND:  aluResult = valRs & valRt;
			execOpPkg::OP_OR:   aluResult = valRs | valRt;
			execOpPkg::OP_XOR:  aluResult = valRs ^ valRt;
			execOpPkg::OP_SHL:  aluResult = valRs << valRt[SHIFT_BITS-1:0];
			execOpPkg::OP_SHR:  aluResult = valRs >> valRt[SHIFT_BITS-1:0];
			execOpPkg::OP_CSEL: aluResult = (valRt != '0) ? valRs : valRm;
			default:            aluResult = valRs;   // MOV and unused codes
		endcase
	end

	// Destination and valid, EX1 -> EX2 -> EX3
	always_ff @(posedge clock) begin
		if (reset) begin
			rn1Id    <= regIdPkg::GR_ZZR;
			rn2Id    <= regIdPkg::GR_ZZR;
			rn3Id    <= regIdPkg::GR_ZZR;
			ex1Valid <= 1'b0;
			ex2Valid <= 1'b0;
			wbValid  <= 1'b0;
		end else if (!hold) begin
			rn1Id    <= idRn;
			rn2Id    <= rn1Id;
			rn3Id    <= rn2Id;
			ex1Valid <= idValid;
			ex2Valid <= ex1Valid;
			wbValid  <= ex2Valid;
		end
	end

	// Result values follow their destination
	always_ff @(posedge clock) begin
		if (!hold) begin
			rn1Val <= aluResult;
			rn2Val <= rn1Val;
			rn3Val <= rn2Val;
		end
	end

	// Decode drops ZZR destinations three stages earlier
	wbHasDest: assert property (@(posedge clock) disable iff (reset)
		wbValid |-> rn3Id != regIdPkg::GR_ZZR)
		else $error("execPipe: writeback valid with ZZR destination");

endmodule

// ==== hw/issueDecode.sv ====
`timescale 1ns/10ps
`include "regFile_config.svh"

module issueDecode (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            hold,
	input  logic                            issueValid,
	input  logic [execOpPkg::INSN_WIDTH-1:0] issueWord,
	input  logic [`REG_IMM_WIDTH-1:0]       issueImm,
	output regIdPkg::regId                  idRs,
	output regIdPkg::regId                  idRt,
	output regIdPkg::regId                  idRm,
	output regIdPkg::regId                  idRn,
	output execOpPkg::aluOp                 idOp,
	output logic [`REG_IMM_WIDTH-1:0]       idImm,
	output logic [`REG_PC_WIDTH-1:0]        idPc,
	output logic                            idValid
);

	logic [`REG_PC_WIDTH-1:0] pcNext;      // Address given to the next issue
	regIdPkg::regId           wordRn;

	assign wordRn = issueWord[execOpPkg::RN_MSB:execOpPkg::RN_LSB];

	always_ff @(posedge clock) begin
		if (reset) begin
			idRs    <= regIdPkg::GR_ZZR;
			idRt    <= regIdPkg::GR_ZZR;
			idRm    <= regIdPkg::GR_ZZR;
			idRn    <= regIdPkg::GR_ZZR;
			idOp    <= execOpPkg::OP_MOV;
			idPc    <= '0;
			idValid <= 1'b0;
			pcNext  <= '0;
		end else if (!hold) begin
			if (issueValid) begin
				idRs    <= issueWord[execOpPkg::RS_MSB:execOpPkg::RS_LSB];
				idRt    <= issueWord[execOpPkg::RT_MSB:execOpPkg::RT_LSB];
				idRm    <= issueWord[execOpPkg::RM_MSB:execOpPkg::RM_LSB];
				idRn    <= wordRn;
				idOp    <= execOpPkg::aluOp'(issueWord[execOpPkg::OP_MSB:execOpPkg::OP_LSB]);
				idPc    <= pcNext;
				idValid <= (wordRn != regIdPkg::GR_ZZR);   // ZZR result is discarded
				pcNext  <= pcNext + `REG_PC_WIDTH'd4;
			end else begin
				// Bubble, reads ZZR and writes nowhere
				idRs    <= regIdPkg::GR_ZZR;
				idRt    <= regIdPkg::GR_ZZR;
				idRm    <= regIdPkg::GR_ZZR;
				idRn    <= regIdPkg::GR_ZZR;
				idOp    <= execOpPkg::OP_MOV;
				idValid <= 1'b0;
			end
		end
	end

	// Immediate is payload only
	always_ff @(posedge clock) begin
		if (!hold && issueValid) begin
			idImm <= issueImm;
		end
	end

	// PC and IMM are read-only pseudo registers
	rnWritable: assert property (@(posedge clock) disable iff (reset)
		idRn != regIdPkg::GR_IMM && idRn != regIdPkg::GR_PC)
		else $error("issueDecode: illegal destination %h", idRn);

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/10ps
`include "regFile_config.svh"

module regFile (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        hold,
	input  regIdPkg::regId              idRs,     // ALU source A
	input  regIdPkg::regId              idRt,     // ALU source B
	input  regIdPkg::regId              idRm,     // Select alternative
	input  regIdPkg::regId              rn1Id,
	input  regIdPkg::regId              rn2Id,
	input  regIdPkg::regId              rn3Id,
	input  logic [`REG_DATA_WIDTH-1:0]  rn1Val,
	input  logic [`REG_DATA_WIDTH-1:0]  rn2Val,
	input  logic [`REG_DATA_WIDTH-1:0]  rn3Val,
	input  logic [`REG_PC_WIDTH-1:0]    pcVal,
	input  logic [`REG_PC_WIDTH-1:0]    gbrVal,
	input  logic [`REG_DATA_WIDTH-1:0]  lrVal,
	input  logic [`REG_IMM_WIDTH-1:0]   immVal,
	output logic [`REG_DATA_WIDTH-1:0]  valRs,
	output logic [`REG_DATA_WIDTH-1:0]  valRt,
	output logic [`REG_DATA_WIDTH-1:0]  valRm,
	output logic [`REG_DATA_WIDTH-1:0]  sprSp
);

	logic [`REG_DATA_WIDTH-1:0] gprArr [regIdPkg::GPR_COUNT];
	logic [`REG_DATA_WIDTH-1:0] sprDlr;
	logic [`REG_DATA_WIDTH-1:0] sprDhr;

	// Stored or synthesized value of one ID
	function automatic logic [`REG_DATA_WIDTH-1:0] readReg(input regIdPkg::regId id);
		logic [`REG_DATA_WIDTH-1:0] val;
		val = '0;
		if (!id[`REG_ID_WIDTH-1]) begin
			val = gprArr[id[`REG_ID_WIDTH-2:0]];
		end else begin
			case (id)
				regIdPkg::GR_DLR: val = sprDlr;
				regIdPkg::GR_DHR: val = sprDhr;
				regIdPkg::GR_SP:  val = sprSp;
				regIdPkg::GR_PC:  val = `REG_DATA_WIDTH'(pcVal);
				regIdPkg::GR_GBR: val = `REG_DATA_WIDTH'(gbrVal);
				regIdPkg::GR_LR:  val = lrVal;
				regIdPkg::GR_IMM: val = `REG_DATA_WIDTH'($signed(immVal));
				default:          val = '0;   // ZZR and unassigned IDs
			endcase
		end
		return val;
	endfunction

	// Youngest in-flight result wins
	function automatic logic [`REG_DATA_WIDTH-1:0] fwdReg(input regIdPkg::regId id);
		logic [`REG_DATA_WIDTH-1:0] val;
		val = readReg(id);
		if (id != regIdPkg::GR_IMM && id != regIdPkg::GR_ZZR) begin
			if (id == rn3Id)
				val = rn3Val;
			if (id == rn2Id)
				val = rn2Val;
			if (id == rn1Id)
				val = rn1Val;
		end
		return val;
	endfunction

	always_comb begin
		valRs = fwdReg(idRs);
		valRt = fwdReg(idRt);
		valRm = fwdReg(idRm);
	end

	// Writeback from EX3 only
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < regIdPkg::GPR_COUNT; i++) begin
				gprArr[i] <= '0;
			end
			sprDlr <= '0;
			sprDhr <= '0;
			sprSp  <= '0;
		end else if (!hold) begin
			if (!rn3Id[`REG_ID_WIDTH-1]) begin
				gprArr[rn3Id[`REG_ID_WIDTH-2:0]] <= rn3Val;
			end
			if (rn3Id == regIdPkg::GR_DLR)
				sprDlr <= rn3Val;
			if (rn3Id == regIdPkg::GR_DHR)
				sprDhr <= rn3Val;
			if (rn3Id == regIdPkg::GR_SP)
				sprSp <= rn3Val;
		end
	end

	// PC is synthesized from decode and has no storage here
	noPcWrite: assert property (@(posedge clock) disable iff (reset)
		rn3Id != regIdPkg::GR_PC)
		else $error("regFile: writeback to PC");

endmodule

// ==== hw/regFile_config.svh ====
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Register and result values
`define REG_DATA_WIDTH 64

// Register ID, upper half holds special and pseudo registers
`define REG_ID_WIDTH 6

// 32-bit immediate plus sign bit
`define REG_IMM_WIDTH 33

// PC, GBR and synthesized address values
`define REG_PC_WIDTH 48

`endif

// ==== hw/regIdPkg.sv ====
`include "regFile_config.svh"

package regIdPkg;

	typedef logic [`REG_ID_WIDTH-1:0] regId;

	localparam int GPR_COUNT = 32;           // R0..R31, lower half of the ID space

	// Special registers, stored in the file
	localparam regId GR_DLR = 6'h20;
	localparam regId GR_DHR = 6'h21;
	localparam regId GR_SP  = 6'h22;

	// Pseudo registers, synthesized on read
	localparam regId GR_PC  = 6'h30;         // PC of the instruction in decode
	localparam regId GR_GBR = 6'h31;
	localparam regId GR_LR  = 6'h32;
	localparam regId GR_IMM = 6'h3E;         // Sign-extended immediate
	localparam regId GR_ZZR = 6'h3F;         // Reads zero, bubble destination

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module execCoreTb -o execCoreSim

./obj_dir/execCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
grep -q "Test passed" sim.log

// ==== test/execCoreModel.svh ====
localparam int WB_ENTRY_WIDTH = `REG_ID_WIDTH + `REG_DATA_WIDTH;

logic [31:0]                lcgState = 32'h3243;
logic [`REG_DATA_WIDTH-1:0] shadowReg [64] = '{default: '0};   // Indexed by register ID
int unsigned                issueCount = 0;                      // PC of the next issue over 4
logic [WB_ENTRY_WIDTH-1:0]  expQueue [$];                        // {id, value} in issue order

function automatic logic [31:0] nextRand();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return lcgState;
endfunction

function automatic regIdPkg::regId randomLowReg();
	return regIdPkg::regId'(nextRand() >> 28);   // R0..R15
endfunction

function automatic logic [`REG_IMM_WIDTH-1:0] randImm();
	return {nextRand() >= 32'h8000_0000, nextRand()};
endfunction

function automatic logic [31:0] makeWord(input execOpPkg::aluOp op, input regIdPkg::regId rn,
		input regIdPkg::regId rs, input regIdPkg::regId rt, input regIdPkg::regId rm);
	return {op, rn, rs, rt, rm, 4'h0};
endfunction

// IDs with storage behind them
function automatic logic isStored(input regIdPkg::regId id);
	return id < 6'd32 || id == regIdPkg::GR_DLR || id == regIdPkg::GR_DHR || id == regIdPkg::GR_SP;
endfunction

function automatic logic [`REG_DATA_WIDTH-1:0] readShadow(input regIdPkg::regId id,
		input logic [`REG_IMM_WIDTH-1:0] imm);
	logic [`REG_DATA_WIDTH-1:0] val;
	val = '0;                                    // ZZR and unknown IDs
	if (isStored(id))
		val = shadowReg[id];
	else if (id == regIdPkg::GR_PC)
		val = `REG_DATA_WIDTH'(issueCount * 4);
	else if (id == regIdPkg::GR_GBR)
		val = `REG_DATA_WIDTH'(gbrVal);
	else if (id == regIdPkg::GR_LR)
		val = lrVal;
	else if (id == regIdPkg::GR_IMM)
		val = {{(`REG_DATA_WIDTH-`REG_IMM_WIDTH){imm[`REG_IMM_WIDTH-1]}}, imm};
	return val;
endfunction

function automatic logic [`REG_DATA_WIDTH-1:0] aluRule(input execOpPkg::aluOp op,
		input logic [`REG_DATA_WIDTH-1:0] rs, input logic [`REG_DATA_WIDTH-1:0] rt,
		input logic [`REG_DATA_WIDTH-1:0] rm);
	logic [`REG_DATA_WIDTH-1:0] val;
	case (op)
		execOpPkg::OP_ADD:  val = rs + rt;
		execOpPkg::OP_SUB:  val = rs - rt;
		execOpPkg::OP_AND:  val = rs & rt;
		execOpPkg::OP_OR:   val = rs | rt;
		execOpPkg::OP_XOR:  val = rs ^ rt;
		execOpPkg::OP_SHL:  val = rs << rt[5:0];
		execOpPkg::OP_SHR:  val = rs >> rt[5:0];
		execOpPkg::OP_CSEL: val = (rt != '0) ? rs : rm;
		default:            val = rs;
	endcase
	return val;
endfunction

// Program order result, forwarding makes it the value the DUT must produce
task automatic recordIssue(input execOpPkg::aluOp op, input regIdPkg::regId rn,
		input regIdPkg::regId rs, input regIdPkg::regId rt, input regIdPkg::regId rm,
		input logic [`REG_IMM_WIDTH-1:0] imm);
	logic [`REG_DATA_WIDTH-1:0] result;
	result = aluRule(op, readShadow(rs, imm), readShadow(rt, imm), readShadow(rm, imm));
	if (rn != regIdPkg::GR_ZZR)
		expQueue.push_back({rn, result});
	if (isStored(rn))
		shadowReg[rn] = result;
	issueCount++;
endtask

// ==== test/execCoreTb.sv ====
`timescale 1ns/10ps
`include "regFile_config.svh"

module execCoreTb;

	localparam int RANDOM_COUNT = 24;
	localparam int MAX_HOLD     = 4;
	localparam int TEST_CYCLES  = 120 + RANDOM_COUNT * (2 + MAX_HOLD);   // Upper bound of stimulus

	logic                       clock;
	logic                       reset;
	logic                       hold;
	logic                       issueValid;
	logic [31:0]                issueWord;
	logic [`REG_IMM_WIDTH-1:0]  issueImm;
	logic [`REG_PC_WIDTH-1:0]   gbrVal;
	logic [`REG_DATA_WIDTH-1:0] lrVal;
	logic                       wbValid;
	regIdPkg::regId             wbId;
	logic [`REG_DATA_WIDTH-1:0] wbValue;
	logic [`REG_DATA_WIDTH-1:0] sprSp;

	`include "execCoreModel.svh"

	logic [2:0]                 wbStage;     // Writing issues in decode, EX1, EX2
	logic                       expWbValid;
	regIdPkg::regId             expWbId;
	logic [`REG_DATA_WIDTH-1:0] expWbValue;
	logic [`REG_DATA_WIDTH-1:0] expSp;
	logic [WB_ENTRY_WIDTH-1:0]  wbEntry;

	execCore execCore_inst (.*);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	task automatic reportFail();
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		$display("MISMATCH %s: got %h expected %h", name, got, expected);
		reportFail();
	endtask

	// Expected EX3 contents frozen while hold is high
	always @(posedge clock) begin
		if (reset) begin
			wbStage    <= '0;
			expWbValid <= 1'b0;
			expSp      <= '0;
		end else if (!hold) begin
			wbStage    <= {wbStage[1:0],
				issueValid && issueWord[execOpPkg::RN_MSB:execOpPkg::RN_LSB] != regIdPkg::GR_ZZR};
			expWbValid <= wbStage[2];
			if (wbStage[2]) begin
				wbEntry = expQueue.pop_front();   // Three cycles after its issue
				{expWbId, expWbValue} <= wbEntry;
			end
			if (expWbValid && expWbId == regIdPkg::GR_SP)
				expSp <= expWbValue;
		end
	end

	wbValidCheck: assert property (@(posedge clock) disable iff (reset) wbValid == expWbValid)
		else reportMismatch("wbValid", 64'($sampled(wbValid)), 64'($sampled(expWbValid)));
	wbIdCheck: assert property (@(posedge clock) disable iff (reset) expWbValid |-> wbId == expWbId)
		else reportMismatch("wbId", 64'($sampled(wbId)), 64'($sampled(expWbId)));
	wbValueCheck: assert property (@(posedge clock) disable iff (reset)
		expWbValid |-> wbValue == expWbValue)
		else reportMismatch("wbValue", $sampled(wbValue), $sampled(expWbValue));
	sprSpCheck: assert property (@(posedge clock) disable iff (reset) sprSp == expSp)
		else reportMismatch("sprSp", $sampled(sprSp), $sampled(expSp));

	task automatic issueInsn(input execOpPkg::aluOp op, input regIdPkg::regId rn,
			input regIdPkg::regId rs, input regIdPkg::regId rt, input regIdPkg::regId rm,
			input logic [`REG_IMM_WIDTH-1:0] imm);
		@(posedge clock);
		issueValid <= 1'b1;
		issueWord  <= makeWord(op, rn, rs, rt, rm);
		issueImm   <= imm;
		hold       <= 1'b0;
		recordIssue(op, rn, rs, rt, rm, imm);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			issueValid <= 1'b0;
			hold       <= 1'b0;
		end
	endtask

	task automatic holdCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			issueValid <= 1'b0;
			hold       <= 1'b1;
		end
	endtask

	initial begin
		#((TEST_CYCLES + 20) * 100);
		$display("Watchdog expired before the stimulus finished");
		reportFail();
	end

	initial begin
		regIdPkg::regId srcA;
		reset      = 1'b1;
		hold       = 1'b0;
		issueValid = 1'b0;
		issueWord  = '0;
		issueImm   = '0;
		gbrVal     = {1'b1, 47'({nextRand(), nextRand()})};   // Top bit set exposes sign extension
		lrVal      = {nextRand(), nextRand()};
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		idleCycles(4);                                 // No writeback out of reset
		for (int i = 0; i < 4; i++)
			issueInsn(execOpPkg::OP_MOV, 6'(i), 6'(8 + i), regIdPkg::GR_ZZR, regIdPkg::GR_ZZR, '0);

		for (int i = 0; i < 16; i++)
			issueInsn(execOpPkg::OP_MOV, 6'(i), regIdPkg::GR_IMM, regIdPkg::GR_ZZR,
				regIdPkg::GR_ZZR, randImm());
		for (int i = 0; i < 9; i++)
			issueInsn(execOpPkg::aluOp'(4'(i)), 6'(16 + i), randomLowReg(), randomLowReg(),
				randomLowReg(), '0);
		issueInsn(execOpPkg::OP_CSEL, 6'd25, 6'd1, regIdPkg::GR_ZZR, 6'd2, '0);   // Picks Rm
		idleCycles(4);

		// Consumer sees EX1, EX2, EX3, then the file
		for (int gap = 0; gap < 4; gap++) begin
			issueInsn(execOpPkg::OP_ADD, 6'd26, 6'(1 + gap), 6'd2, regIdPkg::GR_ZZR, '0);
			idleCycles(gap);
			issueInsn(execOpPkg::OP_SUB, 6'd27, 6'd26, 6'd3, regIdPkg::GR_ZZR, '0);
		end
		issueInsn(execOpPkg::OP_ADD, 6'd28, 6'd1, 6'd2, regIdPkg::GR_ZZR, '0);
		issueInsn(execOpPkg::OP_SUB, 6'd28, 6'd1, 6'd2, regIdPkg::GR_ZZR, '0);
		issueInsn(execOpPkg::OP_XOR, 6'd28, 6'd1, 6'd2, regIdPkg::GR_ZZR, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd29, 6'd28, regIdPkg::GR_ZZR, regIdPkg::GR_ZZR, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd30, 6'd28, regIdPkg::GR_ZZR, regIdPkg::GR_ZZR, '0);
		idleCycles(4);

		issueInsn(execOpPkg::OP_MOV, 6'd30, regIdPkg::GR_ZZR, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, regIdPkg::GR_ZZR, 6'd1, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd31, regIdPkg::GR_PC, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_OR, 6'd16, regIdPkg::GR_GBR, regIdPkg::GR_LR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd17, regIdPkg::GR_GBR, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd18, regIdPkg::GR_LR, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd19, 6'h23, regIdPkg::GR_ZZR, 6'd1, '0);   // Unassigned ID
		issueInsn(execOpPkg::OP_MOV, regIdPkg::GR_SP, 6'd5, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, regIdPkg::GR_DLR, 6'd6, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_ADD, regIdPkg::GR_DHR, 6'd7, 6'd8, 6'd1, '0);
		idleCycles(4);
		issueInsn(execOpPkg::OP_MOV, 6'd20, regIdPkg::GR_DLR, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_MOV, 6'd21, regIdPkg::GR_DHR, regIdPkg::GR_ZZR, 6'd1, '0);
		issueInsn(execOpPkg::OP_ADD, 6'd22, regIdPkg::GR_SP, 6'd1, 6'd1, '0);
		idleCycles(4);

		// Random chains with hold spans while results are in flight
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			srcA = ((nextRand() >> 16) % 4 == 0) ? regIdPkg::GR_IMM : randomLowReg();
			issueInsn(execOpPkg::aluOp'(4'((nextRand() >> 16) % 9)), randomLowReg(), srcA,
				randomLowReg(), randomLowReg(), randImm());
			if ((nextRand() >> 16) % 3 == 0)
				holdCycles(1 + int'((nextRand() >> 16) % MAX_HOLD));
		end
		idleCycles(8);

		if (expQueue.size() != 0 || wbStage != '0) begin
			$display("Writebacks still pending at the end of the run");
			reportFail();
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
+incdir+hw
+incdir+test
hw/regIdPkg.sv
hw/execOpPkg.sv
hw/issueDecode.sv
hw/regFile.sv
hw/execPipe.sv
hw/execCore.sv
test/execCoreTb.sv
